// ==== filelist.f ====
+incdir+verif
source/rv_core_pkg.sv
source/fetch.sv
source/regbank.sv
source/decode.sv
source/execute.sv
source/rv_core.sv
verif/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_rv_core -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned an error status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "No pass line found in sim.log"
    exit 1
fi
exit 0

// ==== verif/tb_iss.svh ====
//////////////////////////////////////////////////////////////////////
// Reference model for the RV32I subset
// Instruction encoders, program builders and an instruction-level
// model that lists the expected store requests in program order
//////////////////////////////////////////////////////////////////////
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// Initial data memory word, depends on the whole word index
function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
endfunction

////////////////////////////////////////////////////////////////////
// Encoders
////////////////////////////////////////////////////////////////////

function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_addr_t rs1,
                                input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic word_t enc_j(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// Program image write pointer
task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
endtask

task automatic clear_prog();
    prog_len = 0;
    for (int i = 0; i < 256; i++) begin
        imem[i] = 32'h0000_0013;
    end
endtask

////////////////////////////////////////////////////////////////////
// Program builders
////////////////////////////////////////////////////////////////////

// Random ALU mix, then every register stored at 0x104 upward
task automatic build_alu();
    word_t r;
    clear_prog();
    for (int k = 0; k < 40; k++) begin
        r = $random(seed);
        case (r[18:16])
            3'd0: emit(enc_i(OPC_OPIMM, 3'b000, r[4:0], r[9:5], r[31:20]));
            3'd1: emit({r[31:12], r[4:0], OPC_LUI});
            3'd2: emit(enc_r(7'b0100000, 3'b000, r[4:0], r[9:5], r[14:10]));
            3'd3: emit(enc_r(7'b0000000, 3'b111, r[4:0], r[9:5], r[14:10]));
            3'd4: emit(enc_r(7'b0000000, 3'b110, r[4:0], r[9:5], r[14:10]));
            3'd5: emit(enc_r(7'b0000000, 3'b100, r[4:0], r[9:5], r[14:10]));
            3'd6: emit(enc_r(7'b0000000, 3'b010, r[4:0], r[9:5], r[14:10]));
            default: emit(enc_r(7'b0000000, 3'b000, r[4:0], r[9:5], r[14:10]));
        endcase
    end
    for (int i = 1; i < 32; i++) begin
        emit(enc_s(reg_addr_t'(i), 5'd0, 12'(256 + 4 * i)));
    end
    // Jump to self ends the program
    emit(enc_j(5'd0, 21'd0));
endtask

// Every instruction uses the result of the one before
task automatic build_dep();
    clear_prog();
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'd3));
    emit(enc_r(7'b0000000, 3'b000, 5'd2, 5'd1, 5'd1));
    emit(enc_r(7'b0100000, 3'b000, 5'd3, 5'd2, 5'd1));
    emit(enc_r(7'b0000000, 3'b100, 5'd4, 5'd3, 5'd2));
    emit(enc_r(7'b0000000, 3'b010, 5'd5, 5'd1, 5'd4));
    emit({20'h12345, 5'd6, OPC_LUI});
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd6, 5'd6, 12'h678));
    emit(enc_r(7'b0000000, 3'b000, 5'd7, 5'd6, 5'd4));
    emit(enc_s(5'd7, 5'd0, 12'h010));
    emit(enc_s(5'd6, 5'd0, 12'h014));
    emit(enc_s(5'd5, 5'd0, 12'h018));
    emit(enc_s(5'd4, 5'd0, 12'h01C));
    emit(enc_j(5'd0, 21'd0));
endtask

// Loads of stored and preset words, each used at once
task automatic build_load();
    clear_prog();
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'd100));
    emit(enc_s(5'd1, 5'd0, 12'h040));
    emit(enc_i(OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h040));
    emit(enc_r(7'b0000000, 3'b000, 5'd3, 5'd2, 5'd2));
    emit(enc_s(5'd3, 5'd0, 12'h044));
    emit(enc_i(OPC_LOAD, 3'b010, 5'd4, 5'd0, 12'h080));
    emit(enc_i(OPC_LOAD, 3'b010, 5'd5, 5'd0, 12'h084));
    emit(enc_r(7'b0000000, 3'b100, 5'd6, 5'd4, 5'd5));
    emit(enc_s(5'd6, 5'd0, 12'h048));
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd8, 5'd0, 12'h040));
    emit(enc_i(OPC_LOAD, 3'b010, 5'd9, 5'd8, 12'h004));
    emit(enc_s(5'd9, 5'd8, 12'h00C));
    emit(enc_j(5'd0, 21'd0));
endtask

// Taken and untaken branches, JAL with link, stores on killed paths
task automatic build_branch();
    clear_prog();
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'd5));
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd2, 5'd0, 12'd5));
    emit(enc_i(OPC_OPIMM, 3'b000, 5'd3, 5'd0, 12'd7));
    emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
    emit(enc_s(5'd3, 5'd0, 12'h060));
    emit(enc_s(5'd1, 5'd0, 12'h064));
    emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
    emit(enc_s(5'd2, 5'd0, 12'h068));
    emit(enc_b(3'b001, 5'd1, 5'd3, 13'd12));
    emit(enc_s(5'd3, 5'd0, 12'h06C));
    emit(enc_s(5'd3, 5'd0, 12'h070));
    emit(enc_b(3'b000, 5'd1, 5'd3, 13'd8));
    emit(enc_j(5'd5, 21'd12));
    emit(enc_s(5'd1, 5'd0, 12'h074));
    emit(enc_s(5'd2, 5'd0, 12'h078));
    emit(enc_s(5'd5, 5'd0, 12'h07C));
    emit(enc_j(5'd0, 21'd0));
endtask

////////////////////////////////////////////////////////////////////
// Instruction-level model
////////////////////////////////////////////////////////////////////

function automatic void tb_iss_run();
    word_t    x [32];
    word_t    dm [1024];
    word_t    pc;
    word_t    nxt;
    word_t    ins;
    word_t    a;
    word_t    b;
    word_t    val;
    word_t    addr;
    logic     wr;
    mem_req_t r;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
        dm[i] = fill_word(i);
    end
    exp_q.delete();
    pc = RESET_PC;
    for (int step = 0; step < 4000; step++) begin
        ins = imem[pc[9:2]];
        a   = x[ins[19:15]];
        b   = x[ins[24:20]];
        nxt = pc + 32'd4;
        wr  = 1'b0;
        val = '0;
        case (ins[6:0])
            OPC_OP: begin
                wr = 1'b1;
                case ({ins[31:25], ins[14:12]})
                    10'h000: val = a + b;
                    10'h100: val = a - b;
                    10'h007: val = a & b;
                    10'h006: val = a | b;
                    10'h004: val = a ^ b;
                    10'h002: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                wr  = ins[14:12] == 3'b000;
                val = a + {{20{ins[31]}}, ins[31:20]};
            end
            OPC_LUI: begin
                wr  = 1'b1;
                val = {ins[31:12], 12'h000};
            end
            OPC_LOAD: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                wr   = ins[14:12] == 3'b010;
                val  = dm[addr[11:2]];
            end
            OPC_STORE: begin
                if (ins[14:12] == 3'b010) begin
                    addr         = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    dm[addr[11:2]] = b;
                    r.en         = 1'b1;
                    r.strb       = 4'hF;
                    r.addr       = addr;
                    r.wdata      = b;
                    exp_q.push_back(r);
                end
            end
            OPC_BRANCH: begin
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                wr  = 1'b1;
                val = pc + 32'd4;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = val;
        end
        // Jump to self is the end of the program
        if (nxt == pc) begin
            break;
        end
        pc = nxt;
    end
endfunction

`endif

// ==== verif/tb_rv_core.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the RV32I core
// Instruction and data memory models, store request checking against
// the reference model, with and without random stall
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_rv_core
    import rv_core_pkg::*;
;

    logic     clk;
    logic     arst_n_i;
    logic     stall_i;
    word_t    instruction_i;
    word_t    mem_data_i;
    word_t    instruction_address_o;
    mem_req_t mem_req_o;

    word_t    imem [0:255];
    word_t    dmem [0:1023];
    mem_req_t exp_q [$];
    int       prog_len;
    integer   seed;
    logic     stall_rand;
    string    test_name;
    int       n_obs;
    int       errors;
    int       timeouts;

    // Memory process locals
    word_t    ia;
    logic     st;
    mem_req_t req;

`include "tb_iss.svh"

    rv_core rv_core_i (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .mem_data_i            (mem_data_i),
        .instruction_address_o (instruction_address_o),
        .mem_req_o             (mem_req_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////////////

    // Inputs sampled at the edge and responses driven 2 ns later
    always @(posedge clk) begin
        ia  = instruction_address_o;
        st  = stall_i;
        req = mem_req_o;
        #2;
        instruction_i = imem[ia[9:2]];
        // Frozen edges leave the data bus alone and keep the read data
        if (!st && req.en) begin
            if (req.strb != '0) begin
                dmem[req.addr[11:2]] = req.wdata;
            end
            else begin
                mem_data_i = dmem[req.addr[11:2]];
            end
        end
    end

    always @(posedge clk) begin
        #2;
        stall_i = stall_rand ? (($random(seed) & 3) == 0) : 1'b0;
    end

    ////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////

    task automatic compare_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_addr(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s fetch address expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s request count expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Store requests in order with one per unfrozen edge
    always @(posedge clk) begin
        if (arst_n_i && !stall_i && mem_req_o.en && mem_req_o.strb != '0) begin
            n_obs++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Store request to %h in test %s was not expected",
                         mem_req_o.addr, test_name);
            end
            else begin
                compare_req(test_name, exp_q.pop_front(), mem_req_o);
            end
        end
    end

    // Reset, load one program, run it and check all its stores
    task automatic run_test(input int id);
        int waited;
        int n_exp;
        @(posedge clk);
        #2;
        arst_n_i = 1'b0;
        case (id)
            0: begin
                test_name = "alu";
                build_alu();
            end
            1: begin
                test_name = "dependencies";
                build_dep();
            end
            2: begin
                test_name = "loads";
                build_load();
            end
            3: begin
                test_name = "branches";
                build_branch();
            end
            default: begin
                test_name = "stall";
                build_branch();
            end
        endcase
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(i);
        end
        tb_iss_run();
        n_exp = exp_q.size();
        n_obs = 0;
        repeat (16) @(posedge clk);
        // Fetch sits at the reset address while reset is held
        compare_addr(test_name, RESET_PC, instruction_address_o);
        stall_rand = (id == 4);
        #2;
        arst_n_i = 1'b1;
        waited   = 0;
        while (n_obs < n_exp && waited < 5000) begin
            @(negedge clk);
            waited++;
        end
        if (n_obs < n_exp) begin
            timeouts++;
            $display("Timeout in test %s, only %0d of %0d stores seen", test_name, n_obs, n_exp);
        end
        else begin
            // Let any stray wrong-path store show up
            waited = 0;
            while (waited < 40) begin
                @(negedge clk);
                waited++;
            end
            compare_count(test_name, n_exp, n_obs);
        end
        stall_rand = 1'b0;
    endtask

    initial begin
        arst_n_i      = 1'b0;
        stall_i       = 1'b0;
        stall_rand    = 1'b0;
        instruction_i = 32'h0000_0013;
        mem_data_i    = '0;
        seed          = 96;
        errors        = 0;
        timeouts      = 0;
        n_obs         = 0;
        test_name     = "none";
        for (int t = 0; t < 5 && timeouts == 0; t++) begin
            run_test(t);
        end
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== source/rv_core.sv ====
//////////////////////////////////////////////////////////////////////
// RV32I pipeline core top level
// Fetch, decode with register read, and execute with retire, joined
// to the instruction bus and to a single data bus
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_core
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  word_t    instruction_i,
    input  word_t    mem_data_i,
    output word_t    instruction_address_o,
    output mem_req_t mem_req_o
);

    ////////////////////////////////////////////////////////////////////
    // Stage to stage signals
    ////////////////////////////////////////////////////////////////////

    // Redirect from execute
    logic      jump;
    word_t     jump_target;
    // Bubble request from decode
    logic      hazard;
    word_t     pc_decode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    decoded_t  decoded;
    wb_t       wb;

    fetch fetch_i (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode)
    );

    decode decode_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .jump_i        (jump),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .decoded_o     (decoded)
    );

    // Write port doubles as the decode bypass
    regbank regbank_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute execute_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .decoded_i     (decoded),
        .mem_data_i    (mem_data_i),
        .mem_req_o     (mem_req_o),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .wb_o          (wb)
    );

endmodule

// ==== source/execute.sv ====
//////////////////////////////////////////////////////////////////////
// Execute and retire stage
// ALU, branch and jump resolution, data bus requests for LW and SW,
// the retire register and selection of the write-back value
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module execute
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  decoded_t decoded_i,
    input  word_t    mem_data_i,
    output mem_req_t mem_req_o,
    output logic     jump_o,
    output word_t    jump_target_o,
    output wb_t      wb_o
);

    word_t   sum;
    word_t   result;
    logic    equal;
    retire_t retire_r;

    ////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////

    // Adder shared by arithmetic, LUI and address generation
    assign sum   = decoded_i.src1 + decoded_i.src2;
    assign equal = decoded_i.src1 == decoded_i.src2;

    always_comb begin
        case (decoded_i.iop)
            ADD, ADDI, LUI, LW, SW: result = sum;
            SUB: result = decoded_i.src1 - decoded_i.src2;
            AND: result = decoded_i.src1 & decoded_i.src2;
            OR:  result = decoded_i.src1 | decoded_i.src2;
            XOR: result = decoded_i.src1 ^ decoded_i.src2;
            // Signed compare, result is zero or one
            SLT: begin
                result = ($signed(decoded_i.src1) < $signed(decoded_i.src2))
                         ? word_t'(1) : word_t'(0);
            end
            // Link address
            JAL:     result = decoded_i.pc + word_t'(4);
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Branch and jump
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (decoded_i.iop)
            BEQ:     jump_o = equal;
            BNE:     jump_o = !equal;
            JAL:     jump_o = 1'b1;
            default: jump_o = 1'b0;
        endcase
    end

    // Both branch and JAL targets are pc relative
    assign jump_target_o = decoded_i.pc + decoded_i.imm;

    ////////////////////////////////////////////////////////////////////
    // Data bus
    ////////////////////////////////////////////////////////////////////

    // Word accesses only, request stays put while the stage is frozen
    always_comb begin
        mem_req_o.en    = (decoded_i.iop == LW) || (decoded_i.iop == SW);
        mem_req_o.strb  = (decoded_i.iop == SW) ? {STRB_W{1'b1}} : {STRB_W{1'b0}};
        mem_req_o.addr  = sum;
        mem_req_o.wdata = decoded_i.store_data;
    end

    ////////////////////////////////////////////////////////////////////
    // Retire
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_r <= '0;
        end
        else if (!stall_i) begin
            retire_r.iop    <= decoded_i.iop;
            retire_r.rd     <= decoded_i.rd;
            retire_r.we     <= decoded_i.rd_we;
            retire_r.result <= result;
        end
    end

    // Load data arrives in the retire cycle
    assign wb_o.we   = retire_r.we;
    assign wb_o.rd   = retire_r.rd;
    assign wb_o.data = (retire_r.iop == LW) ? mem_data_i : retire_r.result;

    // Reads never carry strobes
    a_load_no_strb: assert property (@(posedge clk) disable iff (!arst_n_i)
        (mem_req_o.en && decoded_i.iop == LW) |-> mem_req_o.strb == '0);

    // A store never reaches the register file
    a_store_no_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
        (decoded_i.iop == SW && !stall_i) |=> !wb_o.we);

endmodule

// ==== source/decode.sv ====
//////////////////////////////////////////////////////////////////////
// Decode stage
// Turns the fetched word into an operation and operands, inserts the
// one-cycle bubble on a dependency with execute and squashes the two
// wrong-path slots that follow a taken jump
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module decode
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  word_t     instruction_i,
    input  word_t     pc_i,
    input  logic      jump_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output logic      hazard_o,
    output decoded_t  decoded_o
);

    word_t      held_instr;
    logic       held_valid;
    logic       kill_r;
    word_t      instr;
    logic       squash;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    iop_e       iop;
    logic       rd_we;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       dep;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    decoded_t   next;

    ////////////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////////////

    // Memory keeps sampling while fetch is frozen, so reuse the held word
    assign instr  = held_valid ? held_instr : instruction_i;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        iop = NOP;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: iop = ADD;
                    {7'b0100000, 3'b000}: iop = SUB;
                    {7'b0000000, 3'b111}: iop = AND;
                    {7'b0000000, 3'b110}: iop = OR;
                    {7'b0000000, 3'b100}: iop = XOR;
                    {7'b0000000, 3'b010}: iop = SLT;
                    default:              iop = NOP;
                endcase
            end
            OPC_OPIMM:  iop = (funct3 == 3'b000) ? ADDI : NOP;
            OPC_LUI:    iop = LUI;
            OPC_LOAD:   iop = (funct3 == 3'b010) ? LW : NOP;
            OPC_STORE:  iop = (funct3 == 3'b010) ? SW : NOP;
            OPC_BRANCH: iop = (funct3 == 3'b000) ? BEQ : (funct3 == 3'b001) ? BNE : NOP;
            OPC_JAL:    iop = JAL;
            default:    iop = NOP;
        endcase
    end

    // Source usage and write flag per operation
    always_comb begin
        uses_rs1 = iop inside {ADD, SUB, AND, OR, XOR, SLT, ADDI, LW, SW, BEQ, BNE};
        uses_rs2 = iop inside {ADD, SUB, AND, OR, XOR, SLT, SW, BEQ, BNE};
        rd_we    = iop inside {ADD, SUB, AND, OR, XOR, SLT, ADDI, LUI, LW, JAL};
    end

    // Operand selection where LUI adds its immediate to zero
    always_comb begin
        next            = '0;
        next.iop        = iop;
        next.rd         = instr[11:7];
        next.rd_we      = rd_we;
        next.src1       = (iop == LUI) ? '0 : rs1_data_i;
        next.src2       = rs2_data_i;
        next.store_data = rs2_data_i;
        next.pc         = pc_i;
        case (iop)
            ADDI, LW: begin
                next.src2 = imm_i;
                next.imm  = imm_i;
            end
            SW: begin
                next.src2 = imm_s;
                next.imm  = imm_s;
            end
            LUI: begin
                next.src2 = imm_u;
                next.imm  = imm_u;
            end
            BEQ, BNE: next.imm = imm_b;
            JAL:      next.imm = imm_j;
            default:  next.imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Hazard and squash
    ////////////////////////////////////////////////////////////////////

    // Jump pulse and the slot after it are wrong path
    assign squash = jump_i || kill_r;

    // Result of execute is one cycle short of the register file
    assign dep = decoded_o.rd_we && (decoded_o.rd != '0)
                 && ((uses_rs1 && decoded_o.rd == rs1_o) || (uses_rs2 && decoded_o.rd == rs2_o));
    assign hazard_o = dep && !squash;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            decoded_o  <= '0;
            // First slot after reset carries no fetched word
            kill_r     <= 1'b1;
            held_valid <= 1'b0;
        end
        else begin
            held_valid <= stall_i || hazard_o;
            if (!stall_i) begin
                kill_r <= jump_i;
                if (squash || hazard_o) begin
                    decoded_o <= '0;
                end
                else begin
                    decoded_o <= next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        held_instr <= instr;
    end

endmodule

// ==== source/regbank.sv ====
//////////////////////////////////////////////////////////////////////
// Integer register file
// x1 to x31 in flip-flops, x0 reads as zero, two read ports with
// bypass of the write port in the same cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module regbank
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  wb_t       wb_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [1:31];
    logic  wr_en;

    // Writes to x0 are dropped here
    assign wr_en = wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // One read port, x0 first then bypass then storage
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end
        else if (wr_en && (addr == wb_i.rd)) begin
            data = wb_i.data;
        end
        else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(rs1_i);
    assign rs2_data_o = read_port(rs2_i);

    // Retire may target x0 but never with undefined data
    a_wb_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        (wb_i.we && wb_i.rd == '0) |-> !$isunknown(wb_i.data));

endmodule

// ==== source/fetch.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch stage
// Program counter driving the synchronous instruction memory, with
// redirect on a taken jump and hold on stall or decode hazard
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fetch
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  logic  hazard_i,
    input  logic  jump_i,
    input  word_t jump_target_i,
    output word_t instruction_address_o,
    output word_t pc_o
);

    word_t pc;
    logic  advance;

    // Redirect beats the hazard hold, stall beats both
    assign advance = !stall_i && (jump_i || !hazard_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc   <= RESET_PC;
            pc_o <= RESET_PC;
        end
        else if (advance) begin
            // Address the memory samples now, its word arrives next cycle
            pc_o <= pc;
            if (jump_i) begin
                pc <= jump_target_i;
            end
            else begin
                pc <= pc + word_t'(4);
            end
        end
    end

    assign instruction_address_o = pc;

    // Targets from execute must keep the fetch stream word aligned
    a_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        instruction_address_o[1:0] == 2'b00);

endmodule

// ==== source/rv_core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// RV32I core package
// Data widths, the reset address, major opcodes, the operation enum
// and the packed records that move between the pipeline stages
//////////////////////////////////////////////////////////////////////

package rv_core_pkg;

    // Data path and register index widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    // One strobe per byte of a word
    localparam int STRB_W = XLEN / 8;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // First fetch address out of reset
    localparam word_t RESET_PC = '0;

    ////////////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Decoded operation, NOP must stay at zero so a cleared record is a bubble
    typedef enum logic [3:0] {
        NOP, ADD, SUB, AND, OR, XOR, SLT,
        ADDI, LUI, LW, SW, BEQ, BNE, JAL
    } iop_e;

    ////////////////////////////////////////////////////////////////////
    // Stage records
    ////////////////////////////////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        iop_e      iop;
        reg_addr_t rd;
        logic      rd_we;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        word_t     imm;
        word_t     pc;
    } decoded_t;

    // Retire register inside execute
    typedef struct packed {
        iop_e      iop;
        reg_addr_t rd;
        logic      we;
        word_t     result;
    } retire_t;

    // Register file write port, also seen by decode forwarding
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // Data bus request
    typedef struct packed {
        logic              en;
        logic [STRB_W-1:0] strb;
        word_t             addr;
        word_t             wdata;
    } mem_req_t;

endpackage
